//--- source/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cache geometry
`define CACHE_SETS  16
`define CACHE_WAYS  2
`define BLOCK_WORDS 4

// address split: tag | index | byte offset
`define OFFSET_W 4
`define INDEX_W  4
`define TAG_W    24

// block payload and its byte write mask
`define BLOCK_BITS  128
`define BLOCK_BYTES 16

`endif

//--- source/cache_store_pkg.sv
package cache_store_pkg;

    // per-way state held in the tag/state array
    typedef enum logic [1:0] {
        st_invalid,
        st_clean,
        st_dirty
    } block_state_e;

    // core-side controller FSM
    typedef enum logic [2:0] {
        cs_idle,
        cs_lookup,
        cs_evict,
        cs_fetch,
        cs_wait_fill
    } ctrl_state_e;

endpackage

//--- source/cache_bus_pkg.sv
`include "cache_defs.svh"

package cache_bus_pkg;

    // one request carries a whole block
    typedef enum logic {
        op_read_block,
        op_write_back
    } bus_op_e;

    typedef logic [31:0] bus_addr_t;
    typedef logic [`BLOCK_BITS-1:0] bus_block_t;

endpackage

//--- source/tag_state_array.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module tag_state_array import cache_store_pkg::*; (
    input  logic                                 clk_i,
    input  logic                                 nreset_i,
    input  logic                                 req_i,
    input  logic [`INDEX_W-1:0]                  addr_i,
    input  logic                                 we_i,
    input  logic [`CACHE_WAYS-1:0]               way_mask_i,
    input  logic [`TAG_W-1:0]                    tag_i,
    input  block_state_e                         state_i,
    output logic [`CACHE_WAYS-1:0][`TAG_W-1:0]  tag_o,
    output block_state_e [`CACHE_WAYS-1:0]       state_o,
    output logic                                 sweep_done_o
);

    logic [`TAG_W-1:0] tag_q [`CACHE_WAYS][`CACHE_SETS];
    block_state_e state_q [`CACHE_WAYS][`CACHE_SETS];
    logic [`INDEX_W:0] sweep_cnt_r;

    assign sweep_done_o = sweep_cnt_r == (`INDEX_W+1)'(`CACHE_SETS);

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            sweep_cnt_r <= '0;
        end else if (!sweep_done_o) begin
            sweep_cnt_r <= sweep_cnt_r + 1'b1;
        end
    end

    // sweep owns the array until every set is invalid
    always_ff @(posedge clk_i) begin
        if (!sweep_done_o) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                state_q[w][sweep_cnt_r[`INDEX_W-1:0]] <= st_invalid;
            end
        end else if (req_i && we_i) begin
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                if (way_mask_i[w]) begin
                    tag_q[w][addr_i]   <= tag_i;
                    state_q[w][addr_i] <= state_i;
                end
            end
        end else if (req_i) begin
            // outputs only move on a granted read
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                tag_o[w]   <= tag_q[w][addr_i];
                state_o[w] <= state_q[w][addr_i];
            end
        end
    end

    // peers must stay off the port during the sweep
    a_no_write_in_sweep: assert property (@(posedge clk_i) disable iff (nreset_i)
        !sweep_done_o |-> !(req_i && we_i));

endmodule

//--- source/tag_array_arbiter.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module tag_array_arbiter import cache_store_pkg::*; (
    input  logic                   ctl_req_i,
    input  logic [`INDEX_W-1:0]    ctl_addr_i,
    input  logic                   ctl_we_i,
    input  logic [`CACHE_WAYS-1:0] ctl_way_mask_i,
    input  logic [`TAG_W-1:0]      ctl_tag_i,
    input  block_state_e           ctl_state_i,
    input  logic                   snp_req_i,
    input  logic [`INDEX_W-1:0]    snp_addr_i,
    input  logic                   snp_we_i,
    input  logic [`CACHE_WAYS-1:0] snp_way_mask_i,
    input  logic [`TAG_W-1:0]      snp_tag_i,
    input  block_state_e           snp_state_i,
    output logic                   ctl_gnt_o,
    output logic                   snp_gnt_o,
    output logic                   req_o,
    output logic [`INDEX_W-1:0]    addr_o,
    output logic                   we_o,
    output logic [`CACHE_WAYS-1:0] way_mask_o,
    output logic [`TAG_W-1:0]      tag_o,
    output block_state_e           state_o
);

    // controller always wins, snoop takes idle cycles
    assign ctl_gnt_o = ctl_req_i;
    assign snp_gnt_o = snp_req_i && !ctl_req_i;

    assign req_o      = ctl_req_i || snp_req_i;
    assign addr_o     = ctl_req_i ? ctl_addr_i : snp_addr_i;
    assign we_o       = ctl_req_i ? ctl_we_i : snp_we_i;
    assign way_mask_o = ctl_req_i ? ctl_way_mask_i : snp_way_mask_i;
    assign tag_o      = ctl_req_i ? ctl_tag_i : snp_tag_i;
    assign state_o    = ctl_req_i ? ctl_state_i : snp_state_i;

    always_comb begin
        a_one_grant: assert (!(ctl_gnt_o && snp_gnt_o));
    end

endmodule

//--- source/data_array.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module data_array (
    input  logic                                    clk_i,
    input  logic                                    req_i,
    input  logic [`INDEX_W-1:0]                     addr_i,
    input  logic                                    way_sel_i,
    input  logic                                    we_i,
    input  logic [`BLOCK_BYTES-1:0]                 byte_mask_i,
    input  logic [`BLOCK_BITS-1:0]                  wdata_i,
    output logic [`CACHE_WAYS-1:0][`BLOCK_BITS-1:0] rdata_o
);

    logic [`BLOCK_BITS-1:0] mem_q [`CACHE_WAYS][`CACHE_SETS];

    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            // byte lanes of the selected way only
            for (int b = 0; b < `BLOCK_BYTES; b++) begin
                if (byte_mask_i[b]) begin
                    mem_q[way_sel_i][addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end else if (req_i) begin
            // both ways read, the controller picks after the compare
            for (int w = 0; w < `CACHE_WAYS; w++) begin
                rdata_o[w] <= mem_q[w][addr_i];
            end
        end
    end

endmodule

//--- source/cache_controller.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_controller import cache_store_pkg::*, cache_bus_pkg::*; (
    input  logic                                    clk_i,
    input  logic                                    nreset_i,
    input  logic                                    cc_valid_i,
    output logic                                    cc_ready_o,
    input  logic                                    cc_we_i,
    input  logic [3:0]                              cc_be_i,
    input  logic [31:0]                             cc_addr_i,
    input  logic [31:0]                             cc_wdata_i,
    output logic                                    cc_valid_o,
    output logic [31:0]                             cc_rdata_o,
    output logic                                    cb_valid_o,
    input  logic                                    cb_ready_i,
    output bus_op_e                                 cb_op_o,
    output bus_addr_t                               cb_addr_o,
    output bus_block_t                              cb_wdata_o,
    input  logic                                    cb_resp_valid_i,
    input  bus_block_t                              cb_resp_data_i,
    output logic                                    ctl_req_o,
    output logic [`INDEX_W-1:0]                     ctl_addr_o,
    output logic                                    ctl_we_o,
    output logic [`CACHE_WAYS-1:0]                  ctl_way_mask_o,
    output logic [`TAG_W-1:0]                       ctl_tag_o,
    output block_state_e                            ctl_state_o,
    input  logic                                    ctl_gnt_i,
    input  logic [`CACHE_WAYS-1:0][`TAG_W-1:0]     tag_i,
    input  block_state_e [`CACHE_WAYS-1:0]          state_i,
    input  logic                                    sweep_done_i,
    output logic                                    da_req_o,
    output logic [`INDEX_W-1:0]                     da_addr_o,
    output logic                                    da_way_sel_o,
    output logic                                    da_we_o,
    output logic [`BLOCK_BYTES-1:0]                 da_byte_mask_o,
    output logic [`BLOCK_BITS-1:0]                  da_wdata_o,
    input  logic [`CACHE_WAYS-1:0][`BLOCK_BITS-1:0] da_rdata_i
);

    ctrl_state_e state_r, state_n;
    logic we_r;
    logic [3:0] be_r;
    logic [31:0] addr_r, wdata_r, fill_word_r, hit_word;
    logic [`CACHE_SETS-1:0] lru_r;
    logic way_r, fill_done_r;
    logic [`TAG_W-1:0] victim_tag_r, tag_r;
    block_state_e victim_state_r;
    bus_block_t victim_data_r, fill_block;
    logic [`CACHE_WAYS-1:0] hit;
    logic hit_any, hit_way, victim_way, accept, fill, lookup, hit_write;
    logic [`INDEX_W-1:0] idx_r;
    logic [1:0] word_sel;
    logic [`BLOCK_BYTES-1:0] wmask;

    assign idx_r     = addr_r[`OFFSET_W +: `INDEX_W];
    assign tag_r     = addr_r[31 -: `TAG_W];
    assign word_sel  = addr_r[`OFFSET_W-1:2];
    assign wmask     = `BLOCK_BYTES'(be_r) << {word_sel, 2'b00};
    assign lookup    = state_r == cs_lookup;
    assign fill      = (state_r == cs_wait_fill) && cb_resp_valid_i;
    assign accept    = cc_valid_i && cc_ready_o;
    assign hit_write = lookup && hit_any && we_r;

    // compare against the set read on the accept edge
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit[w] = (state_i[w] != st_invalid) && (tag_i[w] == tag_r);
        end
    end
    assign hit_any  = |hit;
    assign hit_way  = hit[1];
    assign hit_word = da_rdata_i[hit_way][word_sel*32 +: 32];

    // an empty way first, LRU only when the set is full
    assign victim_way = (state_i[0] == st_invalid) ? 1'b0 :
                        (state_i[1] == st_invalid) ? 1'b1 : lru_r[idx_r];

    // fill block with the pending write bytes merged in
    always_comb begin
        fill_block = cb_resp_data_i;
        for (int b = 0; b < `BLOCK_BYTES; b++) begin
            if (we_r && wmask[b]) begin
                fill_block[b*8 +: 8] = wdata_r[(b%4)*8 +: 8];
            end
        end
    end

    always_comb begin
        state_n = state_r;
        case (state_r)
            cs_idle: begin
                if (accept) begin
                    state_n = cs_lookup;
                end
            end
            cs_lookup: begin
                if (hit_any) begin
                    state_n = cs_idle;
                end else if (state_i[victim_way] == st_dirty) begin
                    state_n = cs_evict;
                end else begin
                    state_n = cs_fetch;
                end
            end
            cs_evict: begin
                if (cb_ready_i) begin
                    state_n = cs_fetch;
                end
            end
            cs_fetch: begin
                if (cb_ready_i) begin
                    state_n = cs_wait_fill;
                end
            end
            cs_wait_fill: begin
                if (cb_resp_valid_i) begin
                    state_n = cs_idle;
                end
            end
            default: state_n = cs_idle;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            state_r     <= cs_idle;
            lru_r       <= '0;
            fill_done_r <= 1'b0;
        end else begin
            state_r     <= state_n;
            fill_done_r <= fill;
            // lru bit names the way to evict next
            if (lookup && hit_any) begin
                lru_r[idx_r] <= ~hit_way;
            end else if (fill) begin
                lru_r[idx_r] <= ~way_r;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            we_r    <= cc_we_i;
            be_r    <= cc_be_i;
            addr_r  <= cc_addr_i;
            wdata_r <= cc_wdata_i;
        end
        if (lookup) begin
            way_r          <= victim_way;
            victim_tag_r   <= tag_i[victim_way];
            victim_state_r <= state_i[victim_way];
            victim_data_r  <= da_rdata_i[victim_way];
        end
        if (fill) begin
            fill_word_r <= fill_block[word_sel*32 +: 32];
        end
    end

    assign cc_ready_o = (state_r == cs_idle) && sweep_done_i && ctl_gnt_i;
    assign cc_valid_o = (lookup && hit_any) || fill_done_r;
    assign cc_rdata_o = (cc_valid_o && !we_r) ? (fill_done_r ? fill_word_r : hit_word) : '0;

    // bus request fields hold while the state waits for ready
    assign cb_valid_o = (state_r == cs_evict) || (state_r == cs_fetch);
    assign cb_op_o    = (state_r == cs_evict) ? op_write_back : op_read_block;
    assign cb_addr_o  = (state_r == cs_evict) ? {victim_tag_r, idx_r, `OFFSET_W'(0)} :
                                                {tag_r, idx_r, `OFFSET_W'(0)};
    assign cb_wdata_o = victim_data_r;

    // set read on accept, state update on a write hit or a fill
    assign ctl_req_o      = ((state_r == cs_idle) && cc_valid_i && sweep_done_i) || hit_write || fill;
    assign ctl_addr_o     = (state_r == cs_idle) ? cc_addr_i[`OFFSET_W +: `INDEX_W] : idx_r;
    assign ctl_we_o       = state_r != cs_idle;
    assign ctl_way_mask_o = lookup ? hit : {way_r, ~way_r};
    assign ctl_tag_o      = tag_r;
    assign ctl_state_o    = we_r ? st_dirty : st_clean;

    assign da_req_o       = accept || hit_write || fill;
    assign da_addr_o      = ctl_addr_o;
    assign da_way_sel_o   = lookup ? hit_way : way_r;
    assign da_we_o        = state_r != cs_idle;
    assign da_byte_mask_o = fill ? '1 : wmask;
    assign da_wdata_o     = fill ? fill_block : {`BLOCK_WORDS{wdata_r}};

    a_hit_onehot: assert property (@(posedge clk_i) disable iff (nreset_i)
        lookup |-> $onehot0(hit));

    a_lookup_once: assert property (@(posedge clk_i) disable iff (nreset_i)
        lookup |=> !lookup);

    a_wb_dirty: assert property (@(posedge clk_i) disable iff (nreset_i)
        cb_valid_o && (cb_op_o == op_write_back) |-> victim_state_r == st_dirty);

endmodule

//--- source/snoop_responder.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module snoop_responder import cache_store_pkg::*; (
    input  logic                                clk_i,
    input  logic                                nreset_i,
    input  logic                                snp_valid_i,
    output logic                                snp_ready_o,
    input  logic [31:0]                         snp_addr_i,
    input  logic                                snp_inv_i,
    output logic                                snp_resp_valid_o,
    output logic                                snp_hit_o,
    output block_state_e                        snp_state_o,
    output logic                                snp_ts_req_o,
    output logic [`INDEX_W-1:0]                 snp_ts_addr_o,
    output logic                                snp_ts_we_o,
    output logic [`CACHE_WAYS-1:0]              snp_ts_way_mask_o,
    output logic [`TAG_W-1:0]                   snp_ts_tag_o,
    output block_state_e                        snp_ts_state_o,
    input  logic                                snp_gnt_i,
    input  logic [`CACHE_WAYS-1:0][`TAG_W-1:0] tag_i,
    input  block_state_e [`CACHE_WAYS-1:0]      state_i
);

    logic [`TAG_W-1:0] tag_r;
    logic [`INDEX_W-1:0] index_r;
    logic inv_r, resp_r, wr_pend_r, busy, wr_req;
    logic [`CACHE_WAYS-1:0] hit, way_mask_r;

    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit[w] = (state_i[w] != st_invalid) && (tag_i[w] == tag_r);
        end
    end

    // one snoop at a time, an invalidate that loses the port retries
    assign busy   = resp_r || wr_pend_r;
    assign wr_req = (resp_r && inv_r && |hit) || wr_pend_r;

    assign snp_ts_req_o      = (snp_valid_i && !busy) || wr_req;
    assign snp_ts_addr_o     = busy ? index_r : snp_addr_i[`OFFSET_W +: `INDEX_W];
    assign snp_ts_we_o       = busy;
    assign snp_ts_way_mask_o = resp_r ? hit : way_mask_r;
    assign snp_ts_tag_o      = tag_r;
    assign snp_ts_state_o    = st_invalid;
    assign snp_ready_o       = snp_gnt_i && !busy;

    assign snp_resp_valid_o = resp_r;
    assign snp_hit_o        = resp_r && |hit;
    assign snp_state_o      = !resp_r ? st_invalid :
                              hit[1]  ? state_i[1] :
                              hit[0]  ? state_i[0] : st_invalid;

    always_ff @(posedge clk_i) begin
        if (nreset_i) begin
            resp_r    <= 1'b0;
            wr_pend_r <= 1'b0;
        end else begin
            resp_r    <= snp_valid_i && snp_ready_o;
            wr_pend_r <= wr_req && !snp_gnt_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (snp_valid_i && snp_ready_o) begin
            tag_r   <= snp_addr_i[31 -: `TAG_W];
            index_r <= snp_addr_i[`OFFSET_W +: `INDEX_W];
            inv_r   <= snp_inv_i;
        end
        if (resp_r) begin
            way_mask_r <= hit;
        end
    end

    a_resp_after_handshake: assert property (@(posedge clk_i) disable iff (nreset_i)
        snp_resp_valid_o |-> $past(snp_valid_i && snp_ready_o));

endmodule

//--- source/cache_top.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_top import cache_store_pkg::*, cache_bus_pkg::*; (
    input  logic         clk_i,
    input  logic         nreset_i,
    input  logic         cc_valid_i,
    output logic         cc_ready_o,
    input  logic         cc_we_i,
    input  logic [3:0]   cc_be_i,
    input  logic [31:0]  cc_addr_i,
    input  logic [31:0]  cc_wdata_i,
    output logic         cc_valid_o,
    output logic [31:0]  cc_rdata_o,
    output logic         cb_valid_o,
    input  logic         cb_ready_i,
    output bus_op_e      cb_op_o,
    output bus_addr_t    cb_addr_o,
    output bus_block_t   cb_wdata_o,
    input  logic         cb_resp_valid_i,
    input  bus_block_t   cb_resp_data_i,
    input  logic         snp_valid_i,
    output logic         snp_ready_o,
    input  logic [31:0]  snp_addr_i,
    input  logic         snp_inv_i,
    output logic         snp_resp_valid_o,
    output logic         snp_hit_o,
    output block_state_e snp_state_o
);

    logic ctl_req, ctl_we, ctl_gnt, snp_req, snp_we, snp_gnt, ts_req, ts_we, sweep_done;
    logic [`INDEX_W-1:0] ctl_addr, snp_addr, ts_addr, da_addr;
    logic [`CACHE_WAYS-1:0] ctl_way_mask, snp_way_mask, ts_way_mask;
    logic [`TAG_W-1:0] ctl_tag, snp_tag, ts_tag;
    block_state_e ctl_state, snp_state, ts_state;
    logic [`CACHE_WAYS-1:0][`TAG_W-1:0] ts_tag_q;
    block_state_e [`CACHE_WAYS-1:0] ts_state_q;
    logic da_req, da_way_sel, da_we;
    logic [`BLOCK_BYTES-1:0] da_byte_mask;
    logic [`BLOCK_BITS-1:0] da_wdata;
    logic [`CACHE_WAYS-1:0][`BLOCK_BITS-1:0] da_rdata;

    cache_controller u_ctrl (
        .clk_i, .nreset_i,
        .cc_valid_i, .cc_ready_o, .cc_we_i, .cc_be_i, .cc_addr_i, .cc_wdata_i,
        .cc_valid_o, .cc_rdata_o,
        .cb_valid_o, .cb_ready_i, .cb_op_o, .cb_addr_o, .cb_wdata_o,
        .cb_resp_valid_i, .cb_resp_data_i,
        .ctl_req_o(ctl_req), .ctl_addr_o(ctl_addr), .ctl_we_o(ctl_we),
        .ctl_way_mask_o(ctl_way_mask), .ctl_tag_o(ctl_tag), .ctl_state_o(ctl_state),
        .ctl_gnt_i(ctl_gnt), .tag_i(ts_tag_q), .state_i(ts_state_q), .sweep_done_i(sweep_done),
        .da_req_o(da_req), .da_addr_o(da_addr), .da_way_sel_o(da_way_sel), .da_we_o(da_we),
        .da_byte_mask_o(da_byte_mask), .da_wdata_o(da_wdata), .da_rdata_i(da_rdata)
    );

    snoop_responder u_snoop (
        .clk_i, .nreset_i,
        .snp_valid_i, .snp_ready_o, .snp_addr_i, .snp_inv_i,
        .snp_resp_valid_o, .snp_hit_o, .snp_state_o,
        .snp_ts_req_o(snp_req), .snp_ts_addr_o(snp_addr), .snp_ts_we_o(snp_we),
        .snp_ts_way_mask_o(snp_way_mask), .snp_ts_tag_o(snp_tag), .snp_ts_state_o(snp_state),
        .snp_gnt_i(snp_gnt), .tag_i(ts_tag_q), .state_i(ts_state_q)
    );

    tag_array_arbiter u_arb (
        .ctl_req_i(ctl_req), .ctl_addr_i(ctl_addr), .ctl_we_i(ctl_we),
        .ctl_way_mask_i(ctl_way_mask), .ctl_tag_i(ctl_tag), .ctl_state_i(ctl_state),
        .snp_req_i(snp_req), .snp_addr_i(snp_addr), .snp_we_i(snp_we),
        .snp_way_mask_i(snp_way_mask), .snp_tag_i(snp_tag), .snp_state_i(snp_state),
        .ctl_gnt_o(ctl_gnt), .snp_gnt_o(snp_gnt),
        .req_o(ts_req), .addr_o(ts_addr), .we_o(ts_we),
        .way_mask_o(ts_way_mask), .tag_o(ts_tag), .state_o(ts_state)
    );

    tag_state_array u_tags (
        .clk_i, .nreset_i,
        .req_i(ts_req), .addr_i(ts_addr), .we_i(ts_we), .way_mask_i(ts_way_mask),
        .tag_i(ts_tag), .state_i(ts_state),
        .tag_o(ts_tag_q), .state_o(ts_state_q), .sweep_done_o(sweep_done)
    );

    data_array u_data (
        .clk_i,
        .req_i(da_req), .addr_i(da_addr), .way_sel_i(da_way_sel), .we_i(da_we),
        .byte_mask_i(da_byte_mask), .wdata_i(da_wdata), .rdata_o(da_rdata)
    );

endmodule

//--- tests/cache_tb.sv
`timescale 1ns/1ps
`include "cache_defs.svh"

module cache_tb import cache_store_pkg::*, cache_bus_pkg::*; ();

    localparam int MAX_STEPS = 64;
    localparam int COLS = 6;

    logic clk_i, nreset_i;
    logic cc_valid_i, cc_ready_o, cc_we_i, cc_valid_o;
    logic [3:0] cc_be_i;
    logic [31:0] cc_addr_i, cc_wdata_i, cc_rdata_o;
    logic cb_valid_o, cb_ready_i, cb_resp_valid_i;
    bus_op_e cb_op_o;
    bus_addr_t cb_addr_o;
    bus_block_t cb_wdata_o, cb_resp_data_i;
    logic snp_valid_i, snp_ready_o, snp_inv_i, snp_resp_valid_o, snp_hit_o;
    logic [31:0] snp_addr_i;
    block_state_e snp_state_o;

    logic [31:0] trace_mem [0:MAX_STEPS*COLS-1];
    // backing store keyed by word address
    // untouched words follow the fill rule
    logic [31:0] mem_model [logic [31:0]];
    int n_steps, cycles, value_errs, other_errs, rd_count, wb_count, resp_delay;
    int cycle_limit = 100000;
    logic [31:0] cur_block, resp_addr;
    logic resp_pend;

    cache_top u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles", cycles);
        $display("Regression failed");
        $finish;
    end

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (mem_model.exists(a)) begin
            return mem_model[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    function automatic bus_block_t block_read(input logic [31:0] addr);
        bus_block_t blk;
        for (int w = 0; w < `BLOCK_WORDS; w++) begin
            blk[w*32 +: 32] = mem_word(addr + 32'(4*w));
        end
        return blk;
    endfunction

    // memory side with random ready, delayed single-beat fill and write-back capture
    initial begin
        void'($urandom(32'hfc58d490));
        cb_ready_i = 1'b0;
        cb_resp_valid_i = 1'b0;
        cb_resp_data_i = '0;
        resp_pend = 1'b0;
        resp_delay = 0;
        forever begin
            @(negedge clk_i);
            cb_resp_valid_i = 1'b0;
            if (resp_pend) begin
                resp_delay--;
                if (resp_delay == 0) begin
                    cb_resp_valid_i = 1'b1;
                    cb_resp_data_i = block_read(resp_addr);
                    resp_pend = 1'b0;
                end
            end
            cb_ready_i = ($urandom % 4) != 0;
            #1;
            if (!nreset_i && cb_valid_o && cb_ready_i) begin
                if (cb_op_o == op_write_back) begin
                    wb_count++;
                    if (rd_count != 0) begin
                        $display("write-back came after the block read of 0x%h", cur_block);
                        other_errs++;
                    end
                    for (int w = 0; w < `BLOCK_WORDS; w++) begin
                        mem_model[cb_addr_o + 32'(4*w)] = cb_wdata_o[w*32 +: 32];
                    end
                end else begin
                    rd_count++;
                    if (cb_addr_o !== cur_block) begin
                        $display("FAILED cb_addr_o = %h, expected %h", cb_addr_o, cur_block);
                        value_errs++;
                    end
                    resp_pend = 1'b1;
                    resp_delay = 1 + int'($urandom % 4);
                    resp_addr = cb_addr_o;
                end
            end
        end
    end

    task automatic core_access(input logic we, input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] be, input logic [31:0] exp,
                               input logic [7:0] bus);
        int lat;
        @(negedge clk_i);
        cc_valid_i = 1'b1;
        cc_we_i = we;
        cc_addr_i = addr;
        cc_wdata_i = data;
        cc_be_i = be;
        #1;
        while (!cc_ready_o) begin
            @(negedge clk_i);
            #1;
        end
        // accepted on the rising edge just passed
        @(negedge clk_i);
        cc_valid_i = 1'b0;
        lat = 1;
        #1;
        while (!cc_valid_o) begin
            @(negedge clk_i);
            #1;
            lat++;
        end
        if (cc_rdata_o !== exp) begin
            $display("FAILED cc_rdata_o = %h, expected %h (addr %h)", cc_rdata_o, exp, addr);
            value_errs++;
        end
        if (bus == 8'h00 && lat != 1) begin
            $display("hit at %h answered after %0d cycles instead of one", addr, lat);
            other_errs++;
        end
    endtask

    task automatic snoop_access(input logic inv, input logic [31:0] addr,
                                input logic [31:0] exp);
        @(negedge clk_i);
        snp_valid_i = 1'b1;
        snp_addr_i = addr;
        snp_inv_i = inv;
        #1;
        while (!snp_ready_o) begin
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
        snp_valid_i = 1'b0;
        #1;
        if (!snp_resp_valid_o) begin
            $display("no snoop response one cycle after the handshake for %h", addr);
            other_errs++;
        end else begin
            if (snp_hit_o !== exp[4]) begin
                $display("FAILED snp_hit_o = %h, expected %h (addr %h)", snp_hit_o, exp[4], addr);
                value_errs++;
            end
            if (snp_state_o !== block_state_e'(exp[1:0])) begin
                $display("FAILED snp_state_o = %h, expected %h (addr %h)",
                         snp_state_o, exp[1:0], addr);
                value_errs++;
            end
        end
    endtask

    task automatic run_step(input int i);
        logic [31:0] kind, addr, data, be, exp, bus;
        kind = trace_mem[i*COLS];
        addr = trace_mem[i*COLS+1];
        data = trace_mem[i*COLS+2];
        be   = trace_mem[i*COLS+3];
        exp  = trace_mem[i*COLS+4];
        bus  = trace_mem[i*COLS+5];
        rd_count = 0;
        wb_count = 0;
        cur_block = {addr[31:4], 4'h0};
        if (kind < 2) begin
            core_access(kind[0], addr, data, be[3:0], exp, bus[7:0]);
        end else begin
            snoop_access(kind[0], addr, exp);
        end
        if (rd_count != int'(bus[7:4]) || wb_count != int'(bus[3:0])) begin
            $display("step %0d saw %0d block reads and %0d write-backs, expected %0d and %0d",
                     i, rd_count, wb_count, bus[7:4], bus[3:0]);
            other_errs++;
        end
    endtask

    initial begin
        nreset_i = 1'b1;
        cc_valid_i = 1'b0;
        cc_we_i = 1'b0;
        cc_be_i = '0;
        cc_addr_i = '0;
        cc_wdata_i = '0;
        snp_valid_i = 1'b0;
        snp_addr_i = '0;
        snp_inv_i = 1'b0;
        value_errs = 0;
        other_errs = 0;
        for (int k = 0; k < MAX_STEPS*COLS; k++) begin
            trace_mem[k] = 32'hffffffff;
        end
        $readmemh("tests/cache_trace.txt", trace_mem);
        n_steps = 0;
        while (n_steps < MAX_STEPS && trace_mem[n_steps*COLS] != 32'hffffffff) begin
            n_steps++;
        end
        if (n_steps == 0) begin
            $display("trace file holds no steps");
            other_errs++;
        end
        cycle_limit = 200*n_steps + `CACHE_SETS + 8;

        repeat (8) @(negedge clk_i);
        nreset_i = 1'b0;
        @(negedge clk_i);
        #1;
        if (cc_valid_o || cb_valid_o || snp_ready_o || snp_resp_valid_o) begin
            $display("outputs not idle after reset");
            other_errs++;
        end

        for (int i = 0; i < n_steps; i++) begin
            run_step(i);
        end

        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tests/cache_trace.txt
// kind addr data byte_en expected bus, one step per line
// kind 0 read, 1 write, 2 probe, 3 invalidate; snoop expected = hit*16+state; bus = reads*16+wbs
00000000 00001024 00000000 0 5a5a1024 10
00000000 00001028 00000000 0 5a5a1028 00
00000002 00001020 00000000 0 00000011 00
00000001 00001028 11223344 3 00000000 00
00000000 00001028 00000000 0 5a5a3344 00
00000002 00001020 00000000 0 00000012 00
00000001 00002024 aabbccdd c 00000000 10
00000000 00002024 00000000 0 aabb2024 00
00000000 00002020 00000000 0 5a5a2020 00
00000000 00003020 00000000 0 5a5a3020 11
00000002 00001020 00000000 0 00000000 00
00000000 00001028 00000000 0 5a5a3344 11
00000000 00002024 00000000 0 aabb2024 10
00000002 00002020 00000000 0 00000011 00
00000000 00000040 00000000 0 5a5a0040 10
00000003 00000040 00000000 0 00000011 00
00000002 00000044 00000000 0 00000000 00
00000000 00000048 00000000 0 5a5a0048 10
00000002 00000040 00000000 0 00000011 00
00000001 00000050 01020304 f 00000000 10
00000000 00000050 00000000 0 01020304 00
00000001 0000005c 000000ee 1 00000000 00
00000000 0000005c 00000000 0 5a5a00ee 00
00000002 00000050 00000000 0 00000012 00
00000002 0000ff00 00000000 0 00000000 00
00000000 00000070 00000000 0 5a5a0070 10
00000000 00000170 00000000 0 5a5a0170 10
00000000 00000074 00000000 0 5a5a0074 00
00000000 00000274 00000000 0 5a5a0274 10
00000000 00000078 00000000 0 5a5a0078 00
00000002 00000170 00000000 0 00000000 00
00000000 0000017c 00000000 0 5a5a017c 10
00000001 00000154 99887766 6 00000000 10
00000001 00000258 cafebabe 8 00000000 11
00000000 00000050 00000000 0 01020304 11
00000000 0000005c 00000000 0 5a5a00ee 00
00000000 00000154 00000000 0 5a887754 11
00000000 00000258 00000000 0 ca5a0258 10
ffffffff 00000000 00000000 0 00000000 00

//--- list.f
+incdir+source
source/cache_store_pkg.sv
source/cache_bus_pkg.sv
source/tag_state_array.sv
source/tag_array_arbiter.sv
source/data_array.sv
source/cache_controller.sv
source/snoop_responder.sv
source/cache_top.sv
tests/cache_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator, run, then decide from the log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f list.f --top-module cache_tb -o cache_sim \
    && ./obj_dir/cache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Regression passed$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
